// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC
    } cpu_state_t;

    typedef enum logic [2:0] {
        CL_IMPLIED,
        CL_IMMEDIATE,
        CL_STORE_ZP,
        CL_JMP_ABS,
        CL_BRANCH
    } instr_class_t;

    // ALU_HOLD leaves the ALU output registers alone
    typedef enum logic [2:0] {
        ALU_HOLD,
        ALU_PASS,
        ALU_ADD,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic [1:0] {DST_NONE, DST_A, DST_X, DST_Y} reg_dst_t;

    typedef enum logic [1:0] {SRC_A, SRC_X, SRC_Y, SRC_OPERAND} reg_src_t;

    typedef enum logic [1:0] {FLAG_NONE, FLAG_ALU, FLAG_0, FLAG_1} flag_src_t;

    typedef enum logic [1:0] {BR_C, BR_Z, BR_N, BR_V} branch_flag_t;

    // I comes up set, everything else clears
    localparam logic DEFAULT_I = 1'b1;

    // register or operand byte picked by a reg_src_t
    function automatic byte_t sel_reg(input reg_src_t src, input byte_t a, input byte_t x,
                                      input byte_t y, input byte_t operand);
        byte_t res;
        case (src)
            SRC_A:   res = a;
            SRC_X:   res = x;
            SRC_Y:   res = y;
            default: res = operand;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

// File: design/opcode_decoder.sv
`default_nettype none

module opcode_decoder import cpu_pkg::*; (
    input  wire byte_t    i_opcode,
    output instr_class_t  o_instr_class,
    output alu_op_t       o_alu_op,
    output reg_src_t      o_alu_src,
    output logic          o_alu_carry_in,
    output logic          o_alu_src2_inv,
    output logic          o_alu_const_one,
    output reg_dst_t      o_dst,
    output reg_src_t      o_store_src,
    output flag_src_t     o_n_src,
    output flag_src_t     o_v_src,
    output flag_src_t     o_d_src,
    output flag_src_t     o_i_src,
    output flag_src_t     o_z_src,
    output flag_src_t     o_c_src,
    output branch_flag_t  o_branch_flag,
    output logic          o_branch_inv
);

    reg_dst_t idx_dst;
    reg_src_t idx_src;
    logic     set_nz, set_cv;

    // low two opcode bits name the register for loads and stores
    always_comb begin
        case (i_opcode[1:0])
            2'b01: begin
                idx_dst = DST_A;
                idx_src = SRC_A;
            end
            2'b10: begin
                idx_dst = DST_X;
                idx_src = SRC_X;
            end
            default: begin
                idx_dst = DST_Y;
                idx_src = SRC_Y;
            end
        endcase
    end

    always_comb begin
        // NOP controls unless the table says otherwise
        o_instr_class   = CL_IMPLIED;
        o_alu_op        = ALU_HOLD;
        o_alu_src       = SRC_A;
        o_alu_carry_in  = 1'b0;
        o_alu_src2_inv  = 1'b0;
        o_alu_const_one = 1'b0;
        o_dst           = DST_NONE;
        o_store_src     = SRC_A;
        o_n_src         = FLAG_NONE;
        o_v_src         = FLAG_NONE;
        o_d_src         = FLAG_NONE;
        o_i_src         = FLAG_NONE;
        o_z_src         = FLAG_NONE;
        o_c_src         = FLAG_NONE;
        o_branch_flag   = BR_C;
        o_branch_inv    = 1'b0;
        set_nz          = 1'b0;
        set_cv          = 1'b0;

        case (i_opcode)
            // LDA, LDX, LDY immediate
            8'hA9, 8'hA2, 8'hA0: begin
                o_instr_class = CL_IMMEDIATE;
                o_alu_op      = ALU_PASS;
                o_alu_src     = SRC_OPERAND;
                o_dst         = idx_dst;
                set_nz        = 1'b1;
            end
            // ADC and SBC take carry from C
            8'h69, 8'hE9: begin
                o_instr_class  = CL_IMMEDIATE;
                o_alu_op       = ALU_ADD;
                o_alu_carry_in = 1'b1;
                o_alu_src2_inv = i_opcode[7];
                o_dst          = DST_A;
                set_nz         = 1'b1;
                set_cv         = 1'b1;
            end
            // CMP subtracts without writing A, V untouched
            8'hC9: begin
                o_instr_class  = CL_IMMEDIATE;
                o_alu_op       = ALU_ADD;
                o_alu_src2_inv = 1'b1;
                o_c_src        = FLAG_ALU;
                set_nz         = 1'b1;
            end
            8'h09, 8'h29, 8'h49: begin
                o_instr_class = CL_IMMEDIATE;
                o_dst         = DST_A;
                set_nz        = 1'b1;
                case (i_opcode[6:5])
                    2'b00:   o_alu_op = ALU_OR;
                    2'b01:   o_alu_op = ALU_AND;
                    default: o_alu_op = ALU_XOR;
                endcase
            end
            // INX INY DEX DEY, decrement is +~1 with carry in
            8'hE8, 8'hC8, 8'hCA, 8'h88: begin
                o_alu_op        = ALU_ADD;
                o_alu_const_one = 1'b1;
                o_alu_src2_inv  = (i_opcode == 8'hCA) || (i_opcode == 8'h88);
                o_alu_src       = (i_opcode == 8'hE8 || i_opcode == 8'hCA) ? SRC_X : SRC_Y;
                o_dst           = (i_opcode == 8'hE8 || i_opcode == 8'hCA) ? DST_X : DST_Y;
                set_nz          = 1'b1;
            end
            8'h18: o_c_src = FLAG_0;
            8'h38: o_c_src = FLAG_1;
            8'h58: o_i_src = FLAG_0;
            8'h78: o_i_src = FLAG_1;
            8'hD8: o_d_src = FLAG_0;
            8'hF8: o_d_src = FLAG_1;
            8'hB8: o_v_src = FLAG_0;
            8'h84, 8'h85, 8'h86: begin
                o_instr_class = CL_STORE_ZP;
                o_store_src   = idx_src;
            end
            8'h4C: o_instr_class = CL_JMP_ABS;
            // bits 7:6 pick the flag, bit 5 is the value to branch on
            8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0: begin
                o_instr_class = CL_BRANCH;
                o_branch_inv  = ~i_opcode[5];
                case (i_opcode[7:6])
                    2'b00:   o_branch_flag = BR_N;
                    2'b01:   o_branch_flag = BR_V;
                    2'b10:   o_branch_flag = BR_C;
                    default: o_branch_flag = BR_Z;
                endcase
            end
            default: ;
        endcase

        if (set_nz) begin
            o_n_src = FLAG_ALU;
            o_z_src = FLAG_ALU;
        end
        if (set_cv) begin
            o_c_src = FLAG_ALU;
            o_v_src = FLAG_ALU;
        end
    end

endmodule : opcode_decoder

`default_nettype wire

// File: design/microcode_sequencer.sv
`default_nettype none

module microcode_sequencer import cpu_pkg::*; (
    input  wire                i_clock,
    input  wire                i_arst_n,
    input  wire                i_clock_en,
    input  wire byte_t         i_r_data,
    input  wire instr_class_t  i_instr_class,
    input  wire branch_flag_t  i_branch_flag,
    input  wire                i_branch_inv,
    input  wire                i_flag_c,
    input  wire                i_flag_z,
    input  wire                i_flag_n,
    input  wire                i_flag_v,
    output cpu_state_t         o_state,
    output byte_t              o_opcode,
    output logic               o_branch_taken,
    output logic               o_sync
);

    cpu_state_t next_state;
    logic       cond;

    // flags are already written back by the time decode runs
    always_comb begin
        case (i_branch_flag)
            BR_C:    cond = i_flag_c ^ i_branch_inv;
            BR_Z:    cond = i_flag_z ^ i_branch_inv;
            BR_N:    cond = i_flag_n ^ i_branch_inv;
            default: cond = i_flag_v ^ i_branch_inv;
        endcase
    end

    always_comb begin
        next_state = ST_FETCH;
        case (o_state)
            ST_FETCH: next_state = ST_DECODE;
            ST_DECODE: begin
                if (i_instr_class == CL_STORE_ZP || i_instr_class == CL_JMP_ABS) begin
                    next_state = ST_EXEC;
                end else if (i_instr_class == CL_BRANCH && cond) begin
                    next_state = ST_EXEC;
                end
            end
            default: next_state = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_state        <= ST_FETCH;
            o_opcode       <= 8'hEA;
            o_branch_taken <= 1'b0;
        end else if (i_clock_en) begin
            o_state <= next_state;
            if (o_state == ST_FETCH) begin
                o_opcode <= i_r_data;
            end
            // kept for the execute step of a taken branch
            if (o_state == ST_DECODE) begin
                o_branch_taken <= cond && (i_instr_class == CL_BRANCH);
            end
        end
    end

    assign o_sync = (o_state == ST_FETCH);

endmodule : microcode_sequencer

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu import cpu_pkg::*; (
    input  wire           i_clock,
    input  wire           i_arst_n,
    input  wire           i_clock_en,
    input  wire alu_op_t  i_op,
    input  wire byte_t    i_src1,
    input  wire byte_t    i_src2,
    input  wire           i_src2_inv,
    input  wire           i_carry_in,
    output byte_t         o_result,
    output logic          o_c,
    output logic          o_v,
    output logic          o_z,
    output logic          o_n
);

    byte_t      src2;
    byte_t      res;
    logic [8:0] sum;
    logic       c_next, v_next;

    assign src2 = i_src2_inv ? ~i_src2 : i_src2;
    assign sum  = {1'b0, i_src1} + {1'b0, src2} + {8'h00, i_carry_in};

    always_comb begin
        res    = i_src1;
        c_next = 1'b0;
        v_next = 1'b0;
        case (i_op)
            ALU_ADD: begin
                res    = sum[7:0];
                c_next = sum[8];
                // operands agree in sign, result does not
                v_next = (i_src1[7] == src2[7]) && (sum[7] != i_src1[7]);
            end
            ALU_AND: res = i_src1 & src2;
            ALU_OR:  res = i_src1 | src2;
            ALU_XOR: res = i_src1 ^ src2;
            default: res = i_src1;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_result <= '0;
            o_c      <= 1'b0;
            o_v      <= 1'b0;
            o_z      <= 1'b0;
            o_n      <= 1'b0;
        end else if (i_clock_en && i_op != ALU_HOLD) begin
            o_result <= res;
            o_c      <= c_next;
            o_v      <= v_next;
            o_z      <= (res == 8'h00);
            o_n      <= res[7];
        end
    end

endmodule : alu

`default_nettype wire

// File: design/register_file.sv
`default_nettype none

module register_file import cpu_pkg::*; (
    input  wire              i_clock,
    input  wire              i_arst_n,
    input  wire              i_clock_en,
    input  wire cpu_state_t  i_state,
    input  wire reg_dst_t    i_wb_dst,
    input  wire flag_src_t   i_n_src,
    input  wire flag_src_t   i_v_src,
    input  wire flag_src_t   i_d_src,
    input  wire flag_src_t   i_i_src,
    input  wire flag_src_t   i_z_src,
    input  wire flag_src_t   i_c_src,
    input  wire byte_t       i_alu_result,
    input  wire              i_alu_c,
    input  wire              i_alu_v,
    input  wire              i_alu_z,
    input  wire              i_alu_n,
    output byte_t            o_a,
    output byte_t            o_x,
    output byte_t            o_y,
    output logic             o_flag_n,
    output logic             o_flag_v,
    output logic             o_flag_d,
    output logic             o_flag_i,
    output logic             o_flag_z,
    output logic             o_flag_c
);

    // flag order is N V D I Z C everywhere below
    reg_dst_t   wb_dst_q;
    flag_src_t  src_q [5:0];
    logic [5:0] flags;
    logic [5:0] alu_flags;

    assign alu_flags = {i_alu_n, i_alu_v, 1'b0, 1'b0, i_alu_z, i_alu_c};

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb_dst_q <= DST_NONE;
            src_q    <= '{default: FLAG_NONE};
            o_a      <= '0;
            o_x      <= '0;
            o_y      <= '0;
            flags    <= {3'b000, DEFAULT_I, 2'b00};
        end else if (i_clock_en) begin
            // latch at issue
            if (i_state == ST_DECODE) begin
                wb_dst_q <= i_wb_dst;
                src_q    <= '{i_n_src, i_v_src, i_d_src, i_i_src, i_z_src, i_c_src};
            end
            // ALU result is ready during the following fetch
            if (i_state == ST_FETCH) begin
                case (wb_dst_q)
                    DST_A:   o_a <= i_alu_result;
                    DST_X:   o_x <= i_alu_result;
                    DST_Y:   o_y <= i_alu_result;
                    default: ;
                endcase
                for (int i = 0; i < 6; i++) begin
                    case (src_q[i])
                        FLAG_ALU: flags[i] <= alu_flags[i];
                        FLAG_0:   flags[i] <= 1'b0;
                        FLAG_1:   flags[i] <= 1'b1;
                        default:  ;
                    endcase
                end
            end
        end
    end

    assign {o_flag_n, o_flag_v, o_flag_d, o_flag_i, o_flag_z, o_flag_c} = flags;

endmodule : register_file

`default_nettype wire

// File: design/address_unit.sv
`default_nettype none

module address_unit import cpu_pkg::*; #(
    parameter addr_t P_RESET_PC = 16'h4020
) (
    input  wire                i_clock,
    input  wire                i_arst_n,
    input  wire                i_clock_en,
    input  wire cpu_state_t    i_state,
    input  wire instr_class_t  i_instr_class,
    input  wire                i_branch_taken,
    input  wire byte_t         i_r_data,
    input  wire byte_t         i_store_data,
    output addr_t              o_addr,
    output logic               o_mem_r_en,
    output byte_t              o_w_data,
    output byte_t              o_operand
);

    addr_t pc;
    byte_t operand_q;
    logic  store_cycle;

    // only the store execute step leaves the PC off the bus
    assign store_cycle = (i_state == ST_EXEC) && (i_instr_class == CL_STORE_ZP);
    assign o_addr      = store_cycle ? {8'h00, operand_q} : pc;
    assign o_mem_r_en  = !store_cycle;
    assign o_w_data    = i_store_data;
    assign o_operand   = operand_q;

    ////////////////////////////////////////////////////////////
    // program counter

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc <= P_RESET_PC;
        end else if (i_clock_en) begin
            case (i_state)
                ST_FETCH: pc <= pc + 16'd1;
                ST_DECODE: begin
                    // every non-implied class reads one byte at PC here
                    if (i_instr_class != CL_IMPLIED) begin
                        pc <= pc + 16'd1;
                    end
                end
                ST_EXEC: begin
                    if (i_instr_class == CL_JMP_ABS) begin
                        pc <= {i_r_data, operand_q};
                    end else if (i_instr_class == CL_BRANCH && i_branch_taken) begin
                        pc <= pc + {{8{operand_q[7]}}, operand_q};
                    end
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // operand buffer, zp address, JMP low byte or branch offset

    always_ff @(posedge i_clock) begin
        if (i_clock_en && i_state == ST_DECODE) begin
            operand_q <= i_r_data;
        end
    end

endmodule : address_unit

`default_nettype wire

// File: design/cpu_core.sv
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter addr_t P_RESET_PC = 16'h4020
) (
    input  wire        i_clock,
    input  wire        i_arst_n,
    input  wire        i_clock_en,
    input  wire byte_t i_r_data,
    output addr_t      o_addr,
    output logic       o_mem_r_en,
    output byte_t      o_w_data,
    output logic       o_sync
);

    cpu_state_t   state;
    byte_t        opcode;
    logic         branch_taken;

    instr_class_t instr_class;
    alu_op_t      dec_alu_op;
    reg_src_t     dec_alu_src, dec_store_src;
    logic         dec_carry_in, dec_src2_inv, dec_const_one;
    reg_dst_t     dec_dst;
    flag_src_t    n_src, v_src, d_src, i_src, z_src, c_src;
    branch_flag_t branch_flag;
    logic         branch_inv;

    alu_op_t      alu_op;
    byte_t        alu_src1, alu_src2, alu_result;
    logic         alu_cin, alu_c, alu_v, alu_z, alu_n;

    byte_t        reg_a, reg_x, reg_y, operand, store_data;
    logic         flag_n, flag_v, flag_z, flag_c;

    ////////////////////////////////////////////////////////////
    // control

    microcode_sequencer u_seq (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_clock_en(i_clock_en),
        .i_r_data(i_r_data), .i_instr_class(instr_class),
        .i_branch_flag(branch_flag), .i_branch_inv(branch_inv),
        .i_flag_c(flag_c), .i_flag_z(flag_z), .i_flag_n(flag_n), .i_flag_v(flag_v),
        .o_state(state), .o_opcode(opcode), .o_branch_taken(branch_taken),
        .o_sync(o_sync)
    );

    opcode_decoder u_dec (
        .i_opcode(opcode), .o_instr_class(instr_class), .o_alu_op(dec_alu_op),
        .o_alu_src(dec_alu_src), .o_alu_carry_in(dec_carry_in),
        .o_alu_src2_inv(dec_src2_inv), .o_alu_const_one(dec_const_one),
        .o_dst(dec_dst), .o_store_src(dec_store_src),
        .o_n_src(n_src), .o_v_src(v_src), .o_d_src(d_src),
        .o_i_src(i_src), .o_z_src(z_src), .o_c_src(c_src),
        .o_branch_flag(branch_flag), .o_branch_inv(branch_inv)
    );

    ////////////////////////////////////////////////////////////
    // datapath

    // issue only in decode, the opcode register is stale in fetch
    assign alu_op   = (state == ST_DECODE) ? dec_alu_op : ALU_HOLD;
    assign alu_src1 = sel_reg(dec_alu_src, reg_a, reg_x, reg_y, i_r_data);
    assign alu_src2 = dec_const_one ? 8'h01 : i_r_data;
    // carry from C for ADC/SBC, otherwise set exactly for subtracts
    assign alu_cin  = dec_carry_in ? flag_c : dec_src2_inv;
    assign store_data = sel_reg(dec_store_src, reg_a, reg_x, reg_y, operand);

    alu u_alu (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_clock_en(i_clock_en),
        .i_op(alu_op), .i_src1(alu_src1), .i_src2(alu_src2),
        .i_src2_inv(dec_src2_inv), .i_carry_in(alu_cin),
        .o_result(alu_result), .o_c(alu_c), .o_v(alu_v), .o_z(alu_z), .o_n(alu_n)
    );

    // D and I are architectural only, nothing here reads them
    register_file u_regs (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_clock_en(i_clock_en),
        .i_state(state), .i_wb_dst(dec_dst),
        .i_n_src(n_src), .i_v_src(v_src), .i_d_src(d_src),
        .i_i_src(i_src), .i_z_src(z_src), .i_c_src(c_src),
        .i_alu_result(alu_result), .i_alu_c(alu_c), .i_alu_v(alu_v),
        .i_alu_z(alu_z), .i_alu_n(alu_n),
        .o_a(reg_a), .o_x(reg_x), .o_y(reg_y),
        .o_flag_n(flag_n), .o_flag_v(flag_v), .o_flag_d(), .o_flag_i(),
        .o_flag_z(flag_z), .o_flag_c(flag_c)
    );

    address_unit #(.P_RESET_PC(P_RESET_PC)) u_addr (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_clock_en(i_clock_en),
        .i_state(state), .i_instr_class(instr_class), .i_branch_taken(branch_taken),
        .i_r_data(i_r_data), .i_store_data(store_data),
        .o_addr(o_addr), .o_mem_r_en(o_mem_r_en), .o_w_data(o_w_data),
        .o_operand(operand)
    );

endmodule : cpu_core

`default_nettype wire

// File: bench/cpu_core_assert.sv
`default_nettype none

module cpu_core_assert import cpu_pkg::*; #(
    parameter addr_t P_RESET_PC = 16'h4020
) (
    input wire        i_clock,
    input wire        i_arst_n,
    input wire        i_clock_en,
    input wire addr_t o_addr,
    input wire        o_mem_r_en,
    input wire byte_t o_w_data,
    input wire        o_sync
);

    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // first cycle out of reset is a fetch from the reset vector
    reset_vector: assert property (@(posedge i_clock)
        $rose(i_arst_n) |-> (o_sync && o_mem_r_en && o_addr == P_RESET_PC))
    else begin
        fail_count++;
        $error("first fetch after reset is not a read of the reset vector");
    end

    // a stalled cycle leaves the memory side untouched
    hold_when_stalled: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !i_clock_en |=> ($stable(o_addr) && $stable(o_mem_r_en) && $stable(o_w_data)))
    else begin
        fail_count++;
        $error("memory outputs changed across a disabled cycle");
    end

    no_write_in_fetch: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_sync |-> o_mem_r_en)
    else begin
        fail_count++;
        $error("write enabled during an opcode fetch");
    end

endmodule : cpu_core_assert

bind cpu_core cpu_core_assert #(.P_RESET_PC(P_RESET_PC)) cpu_core_assert_i (
    .i_clock(i_clock), .i_arst_n(i_arst_n), .i_clock_en(i_clock_en),
    .o_addr(o_addr), .o_mem_r_en(o_mem_r_en), .o_w_data(o_w_data), .o_sync(o_sync)
);

`default_nettype wire

// File: bench/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb import cpu_pkg::*; ();

    localparam addr_t P_RESET_PC = 16'h4020;
    localparam int    N_INSTR    = 400;
    localparam int    MAX_CYCLES = N_INSTR * 3 * 2 + 50;

    logic  i_clock    = 1'b0;
    logic  i_arst_n   = 1'b0;
    logic  i_clock_en = 1'b1;
    byte_t i_r_data;
    addr_t o_addr;
    logic  o_mem_r_en;
    byte_t o_w_data;
    logic  o_sync;

    byte_t       mem [0:65535];
    bit          used [0:65535];
    bit          en_pattern [0:MAX_CYCLES-1];
    addr_t       sync_q [$];
    logic [23:0] write_q [$];
    addr_t       exp_pc;
    logic [23:0] exp_wr;
    int          mismatches = 0;
    int          failures = 0;
    bit          done = 1'b0;

    // reference model state
    addr_t pc, fresh;
    byte_t ra, rx, ry, zp_slot;
    bit    fn, fv, fz, fc;

    cpu_core #(.P_RESET_PC(P_RESET_PC)) cpu_core_i (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_clock_en(i_clock_en),
        .i_r_data(i_r_data), .o_addr(o_addr), .o_mem_r_en(o_mem_r_en),
        .o_w_data(o_w_data), .o_sync(o_sync)
    );

    assign i_r_data = mem[o_addr];

    always #5 i_clock = ~i_clock;

    ////////////////////////////////////////////////////////////
    // program builder and 6502 reference model

    task automatic put(input byte_t b);
        mem[pc] = b;
        used[pc] = 1'b1;
        pc = pc + 16'd1;
    endtask

    function automatic bit is_free(input addr_t a, input int n);
        for (int i = 0; i < n; i++) begin
            if (used[16'(a + i)]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic set_nz(input byte_t v);
        fn = v[7];
        fz = (v == 8'h00);
    endtask

    function automatic byte_t reg_of(input reg_dst_t d);
        case (d)
            DST_A:   return ra;
            DST_X:   return rx;
            default: return ry;
        endcase
    endfunction

    task automatic set_reg(input reg_dst_t d, input byte_t v);
        case (d)
            DST_A:   ra = v;
            DST_X:   rx = v;
            default: ry = v;
        endcase
        set_nz(v);
    endtask

    // binary ADC, SBC passes the inverted operand
    task automatic add_to_a(input byte_t m);
        logic [8:0] sum;
        sum = {1'b0, ra} + {1'b0, m} + {8'h00, fc};
        fv = (ra[7] == m[7]) && (sum[7] != ra[7]);
        fc = sum[8];
        set_reg(DST_A, sum[7:0]);
    endtask

    task automatic emit_jmp();
        addr_t target;
        target = fresh + 16'($urandom_range(0, 15));
        while (!is_free(target, 6)) begin
            fresh = fresh + 16'h0100;
            target = fresh;
        end
        fresh = fresh + 16'h0100;
        put(8'h4C);
        put(target[7:0]);
        put(target[15:8]);
        pc = target;
    endtask

    task automatic emit_store(input reg_dst_t d);
        case (d)
            DST_A:   put(8'h85);
            DST_X:   put(8'h86);
            default: put(8'h84);
        endcase
        put(zp_slot);
        write_q.push_back({8'h00, zp_slot, reg_of(d)});
        zp_slot = zp_slot + 8'd1;
    endtask

    task automatic emit_branch();
        byte_t op, off, cand;
        bit    flag, taken;
        addr_t target;
        int    tries;
        op = 8'h10 + 8'($urandom_range(0, 7)) * 8'h20;
        // bits 7:6 pick N V C Z, bit 5 is the value that branches
        case (op[7:6])
            2'b00:   flag = fn;
            2'b01:   flag = fv;
            2'b10:   flag = fc;
            default: flag = fz;
        endcase
        taken = (flag == op[5]);
        used[pc] = 1'b1;
        used[16'(pc + 1)] = 1'b1;
        off = 8'h00;
        tries = 0;
        // offset 0 is the fallback, pc+2 is always free here
        while (taken && tries < 20) begin
            cand = 8'($urandom);
            target = pc + 16'd2 + {{8{cand[7]}}, cand};
            if (is_free(target, 3)) begin
                off = cand;
                tries = 20;
            end
            tries++;
        end
        mem[pc] = op;
        mem[16'(pc + 1)] = off;
        pc = pc + 16'd2;
        if (taken) begin
            pc = pc + {{8{off[7]}}, off};
        end
    endtask

    task automatic build_program();
        reg_dst_t pending, d;
        int       kind, r;
        byte_t    imm;
        addr_t    self_pc;
        pending = DST_NONE;
        pc = P_RESET_PC;
        fresh = P_RESET_PC + 16'h0800;
        ra = 8'h00;
        rx = 8'h00;
        ry = 8'h00;
        {fn, fv, fz, fc} = 4'b0000;
        zp_slot = 8'h00;
        for (int n = 0; n < N_INSTR - 1; n++) begin
            sync_q.push_back(pc);
            imm = 8'($urandom);
            if (!is_free(pc, 6)) begin
                emit_jmp();
            end else if (pending != DST_NONE) begin
                emit_store(pending);
                pending = DST_NONE;
            end else begin
                kind = $urandom_range(0, 11);
                r = $urandom_range(0, 6);
                case (kind)
                    0: begin
                        d = (r % 3 == 0) ? DST_A : (r % 3 == 1) ? DST_X : DST_Y;
                        put((d == DST_A) ? 8'hA9 : (d == DST_X) ? 8'hA2 : 8'hA0);
                        put(imm);
                        set_reg(d, imm);
                        pending = d;
                    end
                    1, 2: begin
                        put((kind == 1) ? 8'h69 : 8'hE9);
                        put(imm);
                        add_to_a((kind == 1) ? imm : ~imm);
                        pending = DST_A;
                    end
                    3: begin
                        case (r % 3)
                            0: begin
                                put(8'h09);
                                set_reg(DST_A, ra | imm);
                            end
                            1: begin
                                put(8'h29);
                                set_reg(DST_A, ra & imm);
                            end
                            default: begin
                                put(8'h49);
                                set_reg(DST_A, ra ^ imm);
                            end
                        endcase
                        put(imm);
                        pending = DST_A;
                    end
                    4: begin
                        put(8'hC9);
                        put(imm);
                        fc = (ra >= imm);
                        set_nz(ra - imm);
                    end
                    5: begin
                        d = (r % 2 == 0) ? DST_X : DST_Y;
                        case (r % 4)
                            0: put(8'hE8);
                            1: put(8'hC8);
                            2: put(8'hCA);
                            default: put(8'h88);
                        endcase
                        set_reg(d, reg_of(d) + ((r % 4 < 2) ? 8'h01 : 8'hFF));
                        pending = d;
                    end
                    6: begin
                        case (r)
                            0: put(8'h18);
                            1: put(8'h38);
                            2: put(8'h58);
                            3: put(8'h78);
                            4: put(8'hD8);
                            5: put(8'hF8);
                            default: put(8'hB8);
                        endcase
                        if (r == 0) fc = 1'b0;
                        if (r == 1) fc = 1'b1;
                        if (r == 6) fv = 1'b0;
                    end
                    7, 8, 9: emit_branch();
                    10: emit_jmp();
                    // undefined opcodes behave as NOP
                    default: put((r < 4) ? 8'hEA : 8'hFF);
                endcase
            end
        end
        // park the core on a jump to itself
        self_pc = pc;
        sync_q.push_back(pc);
        put(8'h4C);
        put(self_pc[7:0]);
        put(self_pc[15:8]);
        sync_q.push_back(self_pc);
    endtask

    ////////////////////////////////////////////////////////////
    // memory writes and checks on enabled edges

    always @(posedge i_clock) begin
        if (i_arst_n && i_clock_en && !done) begin
            if (o_sync) begin
                exp_pc = sync_q.pop_front();
                assert (o_addr == exp_pc) else begin
                    mismatches++;
                    $display("MISMATCH at %0t: fetch from %h, expected %h",
                             $time, o_addr, exp_pc);
                end
                if (sync_q.size() == 0) done = 1'b1;
            end
            if (!o_mem_r_en) begin
                mem[o_addr] <= o_w_data;
                assert (write_q.size() != 0) else begin
                    failures++;
                    $display("write of %h to %h at %0t when no write was left",
                             o_w_data, o_addr, $time);
                end
                if (write_q.size() != 0) begin
                    exp_wr = write_q.pop_front();
                    assert ({o_addr, o_w_data} == exp_wr) else begin
                        mismatches++;
                        $display("MISMATCH at %0t: wrote %h to %h, expected %h to %h",
                                 $time, o_w_data, o_addr, exp_wr[7:0], exp_wr[23:8]);
                    end
                end
            end
        end
    end

    initial begin
        int          cyc;
        int unsigned assert_fails;
        void'($urandom(32'hcb11));
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 8'(a >> 8) ^ 8'(a * 37);
        end
        // roughly one cycle in four stalled
        for (int i = 0; i < MAX_CYCLES; i++) begin
            en_pattern[i] = ($urandom_range(0, 3) != 0);
        end
        build_program();
        repeat (5) @(posedge i_clock);
        #1 i_arst_n = 1'b1;
        cyc = 0;
        while (!done) begin
            @(posedge i_clock);
            #1 i_clock_en = en_pattern[cyc % MAX_CYCLES];
            cyc++;
        end
        i_clock_en = 1'b1;
        repeat (4) @(posedge i_clock);
        if (write_q.size() != 0) begin
            failures++;
            $display("%0d expected writes never happened", write_q.size());
        end
        assert_fails = cpu_core_i.cpu_core_assert_i.fail_count;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, assert_fails);
        if (mismatches == 0 && failures == 0 && assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(MAX_CYCLES * 10);
        $display("timeout: program not finished after %0d cycles", MAX_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule : cpu_core_tb

`default_nettype wire

// File: cpu_core.f
design/cpu_pkg.sv
design/opcode_decoder.sv
design/microcode_sequencer.sv
design/alu.sv
design/register_file.sv
design/address_unit.sv
design/cpu_core.sv
bench/cpu_core_assert.sv
bench/cpu_core_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - design/cpu_pkg.sv
      - design/opcode_decoder.sv
      - design/microcode_sequencer.sv
      - design/alu.sv
      - design/register_file.sv
      - design/address_unit.sv
      - design/cpu_core.sv
  - target: test
    files:
      - bench/cpu_core_assert.sv
      - bench/cpu_core_tb.sv
